//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= apbUartTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/apbUart.sv
`timescale 1ns/1ps
// APB UART top level
// Connects the register file, baud generator, serial paths and interrupt logic
module apbUart (
	input  logic CLK,
	input  logic iRST,
	input  logic PSEL,
	input  logic PENABLE,
	input  logic PWRITE,
	input  uartPkg::regAddr PADDR,
	input  logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic INT,
	input  logic SIN,
	output logic SOUT
);

	uartPkg::apbReq req;
	uartPkg::uartByte rdata;
	uartPkg::lineCfg cfg;
	uartPkg::baudDiv divisor;
	uartPkg::lineStatus status;
	uartPkg::rxChar rxHead;
	uartPkg::fifoCount rxUsage;
	uartPkg::iirCode iir;
	logic [1:0] rxTrigger;
	logic [1:0] rxPushErr;
	logic [3:0] ier;
	logic tick16;
	logic thrWrite;
	logic rbrRead;
	logic iirRead;
	logic ierWrite;
	logic ierWriteEtbei;
	logic txFifoReset;
	logic rxFifoReset;
	logic txEmpty;
	logic txFull;
	logic txBusy;
	logic rxEmpty;
	logic rxFull;
	logic rxPush;

	// Only the low byte of the write data is used
	assign req = '{sel: PSEL, enable: PENABLE, write: PWRITE, addr: PADDR, wdata: PWDATA[7:0]};
	assign PRDATA = {24'b0, rdata};
	assign PREADY = 1'b1;

	uartRegs regs0 (
		.CLK(CLK), .iRST(iRST), .req(req), .rdata(rdata), .cfg(cfg), .divisor(divisor),
		.thrWrite(thrWrite), .rbrRead(rbrRead), .iirRead(iirRead),
		.txFifoReset(txFifoReset), .rxFifoReset(rxFifoReset), .rxTrigger(rxTrigger),
		.ier(ier), .ierWrite(ierWrite), .ierWriteEtbei(ierWriteEtbei),
		.txEmpty(txEmpty), .txFull(txFull), .txBusy(txBusy),
		.rxEmpty(rxEmpty), .rxFull(rxFull), .rxPush(rxPush), .rxPushErr(rxPushErr),
		.rxHead(rxHead), .iir(iir), .status(status)
	);

	uartBaudGen baud0 (.CLK(CLK), .iRST(iRST), .divisor(divisor), .tick16(tick16));

	uartTxPath tx0 (
		.CLK(CLK), .iRST(iRST), .tick16(tick16), .cfg(cfg),
		.thrWrite(thrWrite), .wdata(req.wdata), .fifoReset(txFifoReset),
		.empty(txEmpty), .full(txFull), .busy(txBusy), .SOUT(SOUT)
	);

	uartRxPath rx0 (
		.CLK(CLK), .iRST(iRST), .tick16(tick16), .cfg(cfg), .SIN(SIN),
		.rbrRead(rbrRead), .fifoReset(rxFifoReset), .head(rxHead),
		.empty(rxEmpty), .full(rxFull), .push(rxPush), .pushErr(rxPushErr),
		.usage(rxUsage)
	);

	uartIrq irq0 (
		.CLK(CLK), .iRST(iRST), .ier(ier), .status(status), .rxUsage(rxUsage),
		.rxTrigger(rxTrigger), .thrWrite(thrWrite), .iirRead(iirRead),
		.ierWrite(ierWrite), .ierWriteEtbei(ierWriteEtbei), .iir(iir), .INT(INT)
	);

endmodule

//--- hw/uartBaudGen.sv
`timescale 1ns/1ps
// UART baud generator
// Divides the clock by the divisor latch to give the 16x oversample tick
module uartBaudGen (
	input  logic CLK,
	input  logic iRST,
	input  uartPkg::baudDiv divisor,
	output logic tick16
);

	uartPkg::baudDiv count;
	uartPkg::baudDiv divLast;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			count <= '0;
			divLast <= uartPkg::DivisorReset;
			tick16 <= 1'b0;
		end
		else
		begin
			divLast <= divisor;
			tick16 <= 1'b0;
			// Zero divisor stops the tick
			if (divisor == '0)
				count <= '0;
			else if (divisor != divLast)
				count <= divisor - 16'd1;
			else if (count == '0)
			begin
				count <= divisor - 16'd1;
				tick16 <= 1'b1;
			end
			else
				count <= count - 16'd1;
		end
	end

endmodule

//--- hw/uartFifo.sv
`timescale 1ns/1ps
// UART FIFO
// Register array with read and write pointers, usage count and status flags
module uartFifo #(
	parameter int Width = 8
) (
	input  logic CLK,
	input  logic iRST,
	input  logic clear,
	input  logic push,
	input  logic pop,
	input  logic [Width-1:0] din,
	output logic [Width-1:0] dout,
	output logic empty,
	output logic full,
	output uartPkg::fifoCount usage
);

	logic [Width-1:0] mem [2**uartPkg::FifoDepthLog2];
	logic [uartPkg::FifoDepthLog2-1:0] wrPtr;
	logic [uartPkg::FifoDepthLog2-1:0] rdPtr;
	logic wrEn;
	logic rdEn;

	assign wrEn = push && !full;
	assign rdEn = pop && !empty;
	assign empty = (usage == '0);
	// Count reaches the depth only when every entry is in use
	assign full = usage[uartPkg::FifoDepthLog2];
	assign dout = mem[rdPtr];

	always_ff @(posedge CLK)
	begin
		if (wrEn)
			mem[wrPtr] <= din;
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			usage <= '0;
		end
		else if (clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			usage <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
			if (wrEn && !rdEn)
				usage <= usage + 1'b1;
			else if (rdEn && !wrEn)
				usage <= usage - 1'b1;
		end
	end

	// Callers gate their strobes with the flags
	noPushWhenFull: assert property (@(posedge CLK) disable iff (iRST) push |-> !full);
	noPopWhenEmpty: assert property (@(posedge CLK) disable iff (iRST) pop |-> !empty);

endmodule

//--- hw/uartIrq.sv
`timescale 1ns/1ps
// UART interrupt controller
// THR empty latch and priority encoding of the pending source into the IIR
module uartIrq (
	input  logic CLK,
	input  logic iRST,
	input  logic [3:0] ier,
	input  uartPkg::lineStatus status,
	input  uartPkg::fifoCount rxUsage,
	input  logic [1:0] rxTrigger,
	input  logic thrWrite,
	input  logic iirRead,
	input  logic ierWrite,
	input  logic ierWriteEtbei,
	output uartPkg::iirCode iir,
	output logic INT
);

	uartPkg::fifoCount trigLevel;
	uartPkg::iirCode nextIir;
	logic threLast;
	logic threLatch;
	logic lsPending;
	logic rdaPending;

	always_comb
	begin
		case (rxTrigger)
			2'd0: trigLevel = 5'd1;
			2'd1: trigLevel = 5'd4;
			2'd2: trigLevel = 5'd8;
			default: trigLevel = 5'd14;
		endcase
	end

	assign lsPending = ier[2] && (status.oe || status.pe || status.fe);
	assign rdaPending = ier[0] && (rxUsage >= trigLevel);

	always_comb
	begin
		if (lsPending)
			nextIir = uartPkg::IirRls;
		else if (rdaPending)
			nextIir = uartPkg::IirRda;
		else if (ier[1] && threLatch)
			nextIir = uartPkg::IirThre;
		else
			nextIir = uartPkg::IirNone;
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			threLast <= 1'b0;
			threLatch <= 1'b0;
			iir <= uartPkg::IirNone;
			INT <= 1'b0;
		end
		else
		begin
			threLast <= status.thre;
			if ((status.thre && !threLast) || (ierWrite && ierWriteEtbei && status.thre))
				threLatch <= 1'b1;
			else if ((iirRead && (iir == uartPkg::IirThre)) || thrWrite)
				threLatch <= 1'b0;
			iir <= nextIir;
			INT <= (nextIir != uartPkg::IirNone);
		end
	end

endmodule

//--- hw/uartPkg.sv
// UART shared definitions
// Register map, widths, interrupt codes, bus and data structs, FSM encodings
package uartPkg;

	typedef logic [7:0] uartByte;
	typedef logic [2:0] regAddr;
	typedef logic [15:0] baudDiv;
	typedef logic [4:0] fifoCount;
	typedef logic [3:0] iirCode;

	// Register offsets, MCR and MSR are reserved and read zero
	localparam regAddr AddrRbrThr = 3'd0;
	localparam regAddr AddrIer = 3'd1;
	localparam regAddr AddrIirFcr = 3'd2;
	localparam regAddr AddrLcr = 3'd3;
	localparam regAddr AddrMcr = 3'd4;
	localparam regAddr AddrLsr = 3'd5;
	localparam regAddr AddrMsr = 3'd6;
	localparam regAddr AddrScr = 3'd7;

	localparam int FifoDepthLog2 = 4;
	localparam int OversampleLog2 = 4;
	localparam baudDiv DivisorReset = 16'd1;

	// IIR identification, bit 0 low means an interrupt is pending
	localparam iirCode IirNone = 4'b0001;
	localparam iirCode IirRls = 4'b0110;
	localparam iirCode IirRda = 4'b0100;
	localparam iirCode IirThre = 4'b0010;

	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		regAddr addr;
		uartByte wdata;
	} apbReq;

	// Same bit order as LCR[5:0]
	typedef struct packed {
		logic sp;
		logic eps;
		logic pen;
		logic stb;
		logic [1:0] wls;
	} lineCfg;

	typedef struct packed {
		logic fe;
		logic pe;
		uartByte data;
	} rxChar;

	typedef struct packed {
		logic temt;
		logic thre;
		logic fe;
		logic pe;
		logic oe;
		logic dr;
	} lineStatus;

	typedef enum logic [2:0] {TxIdle, TxStart, TxData, TxParity, TxStop} txState;
	typedef enum logic [2:0] {RxIdle, RxStart, RxData, RxParity, RxStop} rxState;

endpackage

//--- hw/uartRegs.sv
`timescale 1ns/1ps
// UART register file
// APB decode with DLAB banking, configuration registers, sticky line status
// flags and the read data multiplexer
module uartRegs (
	input  logic CLK,
	input  logic iRST,
	input  uartPkg::apbReq req,
	output uartPkg::uartByte rdata,
	output uartPkg::lineCfg cfg,
	output uartPkg::baudDiv divisor,
	output logic thrWrite,
	output logic rbrRead,
	output logic iirRead,
	output logic txFifoReset,
	output logic rxFifoReset,
	output logic [1:0] rxTrigger,
	output logic [3:0] ier,
	output logic ierWrite,
	output logic ierWriteEtbei,
	input  logic txEmpty,
	input  logic txFull,
	input  logic txBusy,
	input  logic rxEmpty,
	input  logic rxFull,
	input  logic rxPush,
	input  logic [1:0] rxPushErr,
	input  uartPkg::rxChar rxHead,
	input  uartPkg::iirCode iir,
	output uartPkg::lineStatus status
);

	uartPkg::uartByte lcr;
	uartPkg::uartByte dll;
	uartPkg::uartByte dlm;
	uartPkg::uartByte scr;
	uartPkg::uartByte rbrLast;
	logic wr;
	logic rd;
	logic dlab;
	logic fcrWrite;
	logic lsrRead;
	logic oeFlag;
	logic peFlag;
	logic feFlag;

	// Access phase of a two-cycle APB transfer
	assign wr = req.sel && req.enable && req.write;
	assign rd = req.sel && req.enable && !req.write;
	assign dlab = lcr[7];

	// THR writes to a full FIFO and RBR reads of an empty one are dropped
	assign thrWrite = wr && (req.addr == uartPkg::AddrRbrThr) && !dlab && !txFull;
	assign rbrRead = rd && (req.addr == uartPkg::AddrRbrThr) && !dlab && !rxEmpty;
	assign ierWrite = wr && (req.addr == uartPkg::AddrIer) && !dlab;
	assign ierWriteEtbei = req.wdata[1];
	assign iirRead = rd && (req.addr == uartPkg::AddrIirFcr);
	assign fcrWrite = wr && (req.addr == uartPkg::AddrIirFcr);
	assign txFifoReset = fcrWrite && req.wdata[2];
	assign rxFifoReset = fcrWrite && req.wdata[1];
	assign lsrRead = rd && (req.addr == uartPkg::AddrLsr);

	assign cfg = uartPkg::lineCfg'(lcr[5:0]);
	assign divisor = {dlm, dll};

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			lcr <= '0;
			ier <= '0;
			scr <= '0;
			dll <= uartPkg::DivisorReset[7:0];
			dlm <= uartPkg::DivisorReset[15:8];
			rxTrigger <= '0;
			rbrLast <= '0;
		end
		else
		begin
			if (wr && (req.addr == uartPkg::AddrLcr))
				lcr <= req.wdata;
			if (ierWrite)
				ier <= req.wdata[3:0];
			if (wr && (req.addr == uartPkg::AddrScr))
				scr <= req.wdata;
			if (wr && (req.addr == uartPkg::AddrRbrThr) && dlab)
				dll <= req.wdata;
			if (wr && (req.addr == uartPkg::AddrIer) && dlab)
				dlm <= req.wdata;
			if (fcrWrite)
				rxTrigger <= req.wdata[7:6];
			if (rbrRead)
				rbrLast <= rxHead.data;
		end
	end

	// Error flags stick until the LSR is read, a new error wins
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			oeFlag <= 1'b0;
			peFlag <= 1'b0;
			feFlag <= 1'b0;
		end
		else
		begin
			if (rxPush && rxFull)
				oeFlag <= 1'b1;
			else if (lsrRead)
				oeFlag <= 1'b0;
			if (rxPush && rxPushErr[0])
				peFlag <= 1'b1;
			else if (lsrRead)
				peFlag <= 1'b0;
			if (rxPush && rxPushErr[1])
				feFlag <= 1'b1;
			else if (lsrRead)
				feFlag <= 1'b0;
		end
	end

	always_comb
	begin
		status.dr = !rxEmpty;
		status.oe = oeFlag;
		status.pe = peFlag;
		status.fe = feFlag;
		status.thre = txEmpty;
		status.temt = txEmpty && !txBusy;
	end

	always_comb
	begin
		case (req.addr)
			uartPkg::AddrRbrThr:
				rdata = dlab ? dll : (rxEmpty ? rbrLast : rxHead.data);
			uartPkg::AddrIer:
				rdata = dlab ? dlm : {4'b0000, ier};
			// FIFOs are always enabled
			uartPkg::AddrIirFcr:
				rdata = {4'b1100, iir};
			uartPkg::AddrLcr:
				rdata = lcr;
			uartPkg::AddrLsr:
				rdata = {1'b0, status.temt, status.thre, 1'b0,
					status.fe, status.pe, status.oe, status.dr};
			uartPkg::AddrScr:
				rdata = scr;
			default:
				rdata = '0;
		endcase
	end

	// An APB access phase always follows a setup phase
	apbSetupFirst: assert property (@(posedge CLK) disable iff (iRST)
		(req.sel && req.enable) |-> $past(req.sel && !req.enable));

endmodule

//--- hw/uartRxPath.sv
`timescale 1ns/1ps
// UART receive path
// SIN synchroniser, mid-bit sampling frame receiver with parity and stop
// checks, and the RX FIFO
module uartRxPath (
	input  logic CLK,
	input  logic iRST,
	input  logic tick16,
	input  uartPkg::lineCfg cfg,
	input  logic SIN,
	input  logic rbrRead,
	input  logic fifoReset,
	output uartPkg::rxChar head,
	output logic empty,
	output logic full,
	output logic push,
	output logic [1:0] pushErr,
	output uartPkg::fifoCount usage
);

	uartPkg::rxState state;
	uartPkg::uartByte shifter;
	uartPkg::rxChar charReg;
	logic [uartPkg::OversampleLog2-1:0] tickCnt;
	logic [2:0] bitCnt;
	logic sinMeta;
	logic sinSync;
	logic parAcc;
	logic peFlag;
	logic parityExp;
	logic midBit;
	logic lastData;
	logic fifoPush;

	// A completed character is dropped when the FIFO has no room
	assign fifoPush = push && !full;
	assign pushErr = {charReg.fe, charReg.pe};

	uartFifo #(.Width($bits(uartPkg::rxChar))) rxFifo (
		.CLK(CLK), .iRST(iRST), .clear(fifoReset),
		.push(fifoPush), .pop(rbrRead), .din(charReg), .dout(head),
		.empty(empty), .full(full), .usage(usage)
	);

	// Eighth tick of each bit
	assign midBit = tick16 && !tickCnt[uartPkg::OversampleLog2-1]
		&& (&tickCnt[uartPkg::OversampleLog2-2:0]);
	assign lastData = (bitCnt == (3'd4 + {1'b0, cfg.wls}));
	assign parityExp = cfg.sp ? !cfg.eps : (parAcc ^ !cfg.eps);

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			sinMeta <= 1'b1;
			sinSync <= 1'b1;
		end
		else
		begin
			sinMeta <= SIN;
			sinSync <= sinMeta;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (midBit && (state == uartPkg::RxData))
			shifter <= {sinSync, shifter[7:1]};
		// Short words arrive in the upper bits and are right aligned here
		if (midBit && (state == uartPkg::RxStop))
			charReg <= '{fe: !sinSync, pe: peFlag, data: shifter >> (2'd3 - cfg.wls)};
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= uartPkg::RxIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			parAcc <= 1'b0;
			peFlag <= 1'b0;
			push <= 1'b0;
		end
		else
		begin
			push <= 1'b0;
			if (tick16)
				tickCnt <= tickCnt + 1'b1;
			case (state)
				uartPkg::RxIdle:
				begin
					if (!sinSync)
					begin
						state <= uartPkg::RxStart;
						tickCnt <= '0;
					end
				end
				uartPkg::RxStart:
				begin
					// A glitch shorter than half a bit aborts the frame
					if (midBit)
					begin
						state <= sinSync ? uartPkg::RxIdle : uartPkg::RxData;
						bitCnt <= '0;
						parAcc <= 1'b0;
						peFlag <= 1'b0;
					end
				end
				uartPkg::RxData:
				begin
					if (midBit)
					begin
						parAcc <= parAcc ^ sinSync;
						bitCnt <= bitCnt + 1'b1;
						if (lastData)
							state <= cfg.pen ? uartPkg::RxParity : uartPkg::RxStop;
					end
				end
				uartPkg::RxParity:
				begin
					if (midBit)
					begin
						peFlag <= (sinSync != parityExp);
						state <= uartPkg::RxStop;
					end
				end
				uartPkg::RxStop:
				begin
					if (midBit)
					begin
						push <= 1'b1;
						state <= uartPkg::RxIdle;
					end
				end
				default:
					state <= uartPkg::RxIdle;
			endcase
		end
	end

	// Line settings hold while a frame is in flight
	cfgStableInFrame: assert property (@(posedge CLK) disable iff (iRST)
		(state != uartPkg::RxIdle) |-> $stable(cfg));

endmodule

//--- hw/uartTxPath.sv
`timescale 1ns/1ps
// UART transmit path
// TX FIFO feeding a frame serializer with parity and 1 or 2 stop bits
module uartTxPath (
	input  logic CLK,
	input  logic iRST,
	input  logic tick16,
	input  uartPkg::lineCfg cfg,
	input  logic thrWrite,
	input  uartPkg::uartByte wdata,
	input  logic fifoReset,
	output logic empty,
	output logic full,
	output logic busy,
	output logic SOUT
);

	uartPkg::txState state;
	uartPkg::uartByte fifoHead;
	uartPkg::uartByte shifter;
	logic [uartPkg::OversampleLog2-1:0] tickCnt;
	logic [2:0] bitCnt;
	logic parAcc;
	logic parityBit;
	logic bitEnd;
	logic lastData;
	logic lastStop;
	logic pop;

	uartFifo #(.Width(8)) txFifo (
		.CLK(CLK), .iRST(iRST), .clear(fifoReset),
		.push(thrWrite), .pop(pop), .din(wdata), .dout(fifoHead),
		.empty(empty), .full(full), .usage()
	);

	assign bitEnd = tick16 && (tickCnt == '1);
	assign lastData = (bitCnt == (3'd4 + {1'b0, cfg.wls}));
	assign lastStop = !cfg.stb || bitCnt[0];
	// Stick parity overrides the computed value
	assign parityBit = cfg.sp ? !cfg.eps : ((parAcc ^ shifter[0]) ^ !cfg.eps);
	// Back to back frames pop at the end of the last stop bit
	assign pop = !empty && ((state == uartPkg::TxIdle)
		|| ((state == uartPkg::TxStop) && bitEnd && lastStop));
	assign busy = (state != uartPkg::TxIdle);

	always_ff @(posedge CLK)
	begin
		if (pop)
			shifter <= fifoHead;
		else if (bitEnd && (state == uartPkg::TxData) && !lastData)
			shifter <= shifter >> 1;
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= uartPkg::TxIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			parAcc <= 1'b0;
			SOUT <= 1'b1;
		end
		else
		begin
			if (tick16)
				tickCnt <= tickCnt + 1'b1;
			if (pop)
			begin
				state <= uartPkg::TxStart;
				tickCnt <= '0;
				SOUT <= 1'b0;
			end
			else if (bitEnd)
			begin
				case (state)
					uartPkg::TxStart:
					begin
						state <= uartPkg::TxData;
						bitCnt <= '0;
						parAcc <= 1'b0;
						SOUT <= shifter[0];
					end
					uartPkg::TxData:
					begin
						if (lastData)
						begin
							bitCnt <= '0;
							state <= cfg.pen ? uartPkg::TxParity : uartPkg::TxStop;
							SOUT <= cfg.pen ? parityBit : 1'b1;
						end
						else
						begin
							bitCnt <= bitCnt + 1'b1;
							parAcc <= parAcc ^ shifter[0];
							SOUT <= shifter[1];
						end
					end
					uartPkg::TxParity:
					begin
						state <= uartPkg::TxStop;
						SOUT <= 1'b1;
					end
					uartPkg::TxStop:
					begin
						if (lastStop)
							state <= uartPkg::TxIdle;
						else
							bitCnt <= bitCnt + 1'b1;
					end
					default:
						state <= uartPkg::TxIdle;
				endcase
			end
		end
	end

endmodule

//--- src.f
hw/uartPkg.sv
hw/uartFifo.sv
hw/uartBaudGen.sv
hw/uartRegs.sv
hw/uartTxPath.sv
hw/uartRxPath.sv
hw/uartIrq.sv
hw/apbUart.sv
verif/apbUartTb.sv

//--- verif/apbUartTb.sv
`timescale 1ns/1ps
// APB UART testbench
// Register access, transmit and receive frames from a stimulus table,
// overrun and interrupt identification
module apbUartTb;

	localparam int ClkPeriod = 100;
	localparam int ResetCycles = 16;
	localparam uartPkg::uartByte DllValue = 8'd1;
	localparam int BitClocks = 16 * DllValue;
	localparam int BitNs = BitClocks * ClkPeriod;
	localparam int TableLen = 11;
	localparam int OverrunChars = 17;
	localparam int PollLimit = 100;
	// TX and RX pass over the table, the overrun burst and two interrupt frames
	localparam int FrameTotal = 2 * TableLen + OverrunChars + 2;
	localparam int WatchdogNs = FrameTotal * 12 * BitNs * 4;

	localparam logic [1:0] ErrNone = 2'd0;
	localparam logic [1:0] ErrParity = 2'd1;
	localparam logic [1:0] ErrStop = 2'd2;

	typedef struct packed {
		uartPkg::uartByte lcr;
		uartPkg::uartByte data;
		logic [1:0] err;
		uartPkg::uartByte want;
	} stimEntry;

	// LCR, data, injected error, data expected after masking to the word length
	stimEntry stimTable [TableLen] = '{
		'{8'h03, 8'hA5, ErrNone, 8'hA5},
		'{8'h00, 8'h3C, ErrNone, 8'h1C},
		'{8'h0B, 8'h96, ErrNone, 8'h96},
		'{8'h1A, 8'hF1, ErrNone, 8'h71},
		'{8'h3D, 8'h5E, ErrNone, 8'h1E},
		'{8'h2F, 8'hC3, ErrNone, 8'hC3},
		'{8'h07, 8'h81, ErrNone, 8'h81},
		'{8'h1B, 8'h6D, ErrParity, 8'h6D},
		'{8'h03, 8'h2B, ErrStop, 8'h2B},
		'{8'h0A, 8'hE7, ErrParity, 8'h67},
		'{8'h05, 8'h9A, ErrStop, 8'h1A}
	};

	logic CLK;
	logic iRST;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	uartPkg::regAddr PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic PREADY;
	logic INT;
	logic SIN;
	logic SOUT;
	integer seed;
	uartPkg::uartByte sent[$];

	apbUart dut0 (
		.CLK(CLK), .iRST(iRST), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
		.INT(INT), .SIN(SIN), .SOUT(SOUT)
	);

	always
	begin
		#(ClkPeriod / 2) CLK = ~CLK;
	end

	task automatic failRun(input string msg);
		begin
			$display("%s", msg);
			$display("Test failed");
			$fatal(1, "simulation stopped on the first error");
		end
	endtask

	task automatic checkByte(input string what, input uartPkg::uartByte got,
		input uartPkg::uartByte exp);
		begin
			if (got !== exp)
				failRun($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
					$time, what, got, exp));
		end
	endtask

	task automatic checkIir(input string what, input uartPkg::iirCode got,
		input uartPkg::iirCode exp);
		begin
			if (got !== exp)
				failRun($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
					$time, what, got, exp));
		end
	endtask

	task automatic checkBit(input string what, input logic got, input logic exp);
		begin
			if (got !== exp)
				failRun($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
					$time, what, got, exp));
		end
	endtask

	task automatic randomByte(output uartPkg::uartByte value);
		integer r;
		begin
			r = $random(seed);
			value = r[7:0];
		end
	endtask

	// Parity bit from the LCR rules, stick parity is the inverse of EPS
	function automatic logic expectParity(input uartPkg::uartByte lcr,
		input uartPkg::uartByte data);
		uartPkg::uartByte mask;
		begin
			mask = 8'hFF >> (2'd3 - lcr[1:0]);
			if (lcr[5])
				return !lcr[4];
			return (^(data & mask)) ^ !lcr[4];
		end
	endfunction

	task automatic apbWrite(input uartPkg::regAddr addr, input uartPkg::uartByte data);
		begin
			@(negedge CLK);
			PSEL = 1'b1;
			PWRITE = 1'b1;
			PADDR = addr;
			PWDATA = {24'h0, data};
			@(negedge CLK);
			PENABLE = 1'b1;
			@(negedge CLK);
			PSEL = 1'b0;
			PENABLE = 1'b0;
			PWRITE = 1'b0;
		end
	endtask

	task automatic apbRead(input uartPkg::regAddr addr, output uartPkg::uartByte data);
		begin
			@(negedge CLK);
			PSEL = 1'b1;
			PWRITE = 1'b0;
			PADDR = addr;
			@(negedge CLK);
			// Read data is already settled for the access cycle
			data = PRDATA[7:0];
			checkBit("PRDATA upper bits", |PRDATA[31:8], 1'b0);
			checkBit("PREADY", PREADY, 1'b1);
			PENABLE = 1'b1;
			@(negedge CLK);
			PSEL = 1'b0;
			PENABLE = 1'b0;
		end
	endtask

	task automatic pollLsr(input int bitIdx, output uartPkg::uartByte lsr);
		int tries;
		begin
			tries = 0;
			apbRead(uartPkg::AddrLsr, lsr);
			while (!lsr[bitIdx])
			begin
				tries++;
				if (tries > PollLimit)
					failRun($sformatf("LSR bit %0d was never set", bitIdx));
				apbRead(uartPkg::AddrLsr, lsr);
			end
		end
	endtask

	task automatic waitInt();
		int cycles;
		begin
			cycles = 0;
			while (INT !== 1'b1)
			begin
				@(negedge CLK);
				cycles++;
				if (cycles > PollLimit * 3)
					failRun("INT was never raised");
			end
		end
	endtask

	task automatic holdBit(input logic level);
		begin
			SIN = level;
			repeat (BitClocks) @(negedge CLK);
		end
	endtask

	task automatic sendFrame(input uartPkg::uartByte lcr, input uartPkg::uartByte data,
		input logic [1:0] err);
		int nBits;
		int i;
		begin
			nBits = 5 + int'(lcr[1:0]);
			@(negedge CLK);
			holdBit(1'b0);
			for (i = 0; i < nBits; i++)
				holdBit(data[i]);
			if (lcr[3])
				holdBit(expectParity(lcr, data) ^ (err == ErrParity));
			holdBit(err == ErrStop ? 1'b0 : 1'b1);
			if (lcr[2])
				holdBit(1'b1);
			// Idle gap before the next frame
			holdBit(1'b1);
			holdBit(1'b1);
		end
	endtask

	task automatic captureFrame(input uartPkg::uartByte lcr, output uartPkg::uartByte data,
		output logic par, output logic stopOk);
		int nBits;
		int i;
		begin
			data = '0;
			par = 1'b0;
			nBits = 5 + int'(lcr[1:0]);
			@(negedge SOUT);
			// Half a bit in, then one bit period between samples
			repeat (BitClocks / 2) @(negedge CLK);
			checkBit("TX start bit", SOUT, 1'b0);
			for (i = 0; i < nBits; i++)
			begin
				repeat (BitClocks) @(negedge CLK);
				data[i] = SOUT;
			end
			if (lcr[3])
			begin
				repeat (BitClocks) @(negedge CLK);
				par = SOUT;
			end
			repeat (BitClocks) @(negedge CLK);
			stopOk = SOUT;
			if (lcr[2])
			begin
				repeat (BitClocks) @(negedge CLK);
				stopOk = stopOk & SOUT;
			end
		end
	endtask

	initial
	begin
		#(WatchdogNs);
		failRun("Watchdog expired, the tests did not finish in time");
	end

	initial
	begin
		stimEntry e;
		uartPkg::uartByte rd;
		uartPkg::uartByte got;
		uartPkg::uartByte b;
		logic par;
		logic stopOk;
		int i;

		CLK = 1'b0;
		iRST = 1'b1;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		SIN = 1'b1;
		seed = 32'hd068bb50;
		repeat (ResetCycles) @(negedge CLK);
		iRST = 1'b0;

		// Reset values
		apbRead(uartPkg::AddrLcr, rd);
		checkByte("LCR reset", rd, 8'h00);
		apbRead(uartPkg::AddrIer, rd);
		checkByte("IER reset", rd, 8'h00);
		apbRead(uartPkg::AddrScr, rd);
		checkByte("SCR reset", rd, 8'h00);
		apbRead(uartPkg::AddrIirFcr, rd);
		checkIir("IIR reset", rd[3:0], uartPkg::IirNone);
		checkBit("IIR FIFO bits", rd[7] & rd[6], 1'b1);
		apbRead(uartPkg::AddrLsr, rd);
		checkByte("LSR reset", rd, 8'h60);
		checkBit("INT reset", INT, 1'b0);

		// Divisor latches behind DLAB
		apbWrite(uartPkg::AddrLcr, 8'h80);
		apbRead(uartPkg::AddrRbrThr, rd);
		checkByte("DLL reset", rd, DllValue);
		apbRead(uartPkg::AddrIer, rd);
		checkByte("DLM reset", rd, 8'h00);
		apbWrite(uartPkg::AddrRbrThr, 8'h5A);
		apbWrite(uartPkg::AddrIer, 8'hA5);
		apbRead(uartPkg::AddrRbrThr, rd);
		checkByte("DLL readback", rd, 8'h5A);
		apbRead(uartPkg::AddrIer, rd);
		checkByte("DLM readback", rd, 8'hA5);
		apbWrite(uartPkg::AddrRbrThr, DllValue);
		apbWrite(uartPkg::AddrIer, 8'h00);
		apbWrite(uartPkg::AddrLcr, 8'h1B);
		apbRead(uartPkg::AddrLcr, rd);
		checkByte("LCR readback", rd, 8'h1B);
		randomByte(b);
		apbWrite(uartPkg::AddrScr, b);
		apbRead(uartPkg::AddrScr, rd);
		checkByte("SCR readback", rd, b);
		apbRead(uartPkg::AddrMsr, rd);
		checkByte("reserved MSR", rd, 8'h00);

		for (i = 0; i < TableLen; i++)
		begin
			e = stimTable[i];
			apbWrite(uartPkg::AddrLcr, e.lcr);
			fork
				apbWrite(uartPkg::AddrRbrThr, e.data);
				captureFrame(e.lcr, got, par, stopOk);
			join
			checkByte("TX data", got, e.want);
			if (e.lcr[3])
				checkBit("TX parity", par, expectParity(e.lcr, e.data));
			checkBit("TX stop", stopOk, 1'b1);
			pollLsr(6, rd);
			checkBit("LSR THRE", rd[5], 1'b1);
		end

		for (i = 0; i < TableLen; i++)
		begin
			e = stimTable[i];
			apbWrite(uartPkg::AddrLcr, e.lcr);
			sendFrame(e.lcr, e.data, e.err);
			pollLsr(0, rd);
			checkBit("LSR PE", rd[2], e.err == ErrParity);
			checkBit("LSR FE", rd[3], e.err == ErrStop);
			apbRead(uartPkg::AddrLsr, rd);
			checkBit("LSR PE cleared", rd[2], 1'b0);
			checkBit("LSR FE cleared", rd[3], 1'b0);
			apbRead(uartPkg::AddrRbrThr, rd);
			checkByte("RBR", rd, e.want);
		end

		// One character more than the RX FIFO holds
		apbWrite(uartPkg::AddrLcr, 8'h03);
		apbWrite(uartPkg::AddrIirFcr, 8'h06);
		apbRead(uartPkg::AddrLsr, rd);
		for (i = 0; i < OverrunChars; i++)
		begin
			randomByte(b);
			sent.push_back(b);
			sendFrame(8'h03, b, ErrNone);
		end
		apbRead(uartPkg::AddrLsr, rd);
		checkBit("LSR OE", rd[1], 1'b1);
		checkBit("LSR DR", rd[0], 1'b1);
		for (i = 0; i < OverrunChars - 1; i++)
		begin
			apbRead(uartPkg::AddrRbrThr, rd);
			checkByte("RBR after overrun", rd, sent[i]);
		end
		apbRead(uartPkg::AddrLsr, rd);
		checkBit("LSR DR drained", rd[0], 1'b0);
		checkBit("LSR OE cleared", rd[1], 1'b0);

		// Received data available at trigger level 1
		apbWrite(uartPkg::AddrIirFcr, 8'h06);
		apbWrite(uartPkg::AddrIer, 8'h01);
		randomByte(b);
		sendFrame(8'h03, b, ErrNone);
		waitInt();
		apbRead(uartPkg::AddrIirFcr, rd);
		checkIir("IIR data available", rd[3:0], uartPkg::IirRda);
		apbRead(uartPkg::AddrRbrThr, rd);
		checkByte("RBR with ERBI", rd, b);
		apbRead(uartPkg::AddrIirFcr, rd);
		checkIir("IIR after RBR read", rd[3:0], uartPkg::IirNone);

		// THR empty, cleared by the IIR read that reports it
		apbWrite(uartPkg::AddrIer, 8'h02);
		waitInt();
		apbRead(uartPkg::AddrIirFcr, rd);
		checkIir("IIR THR empty", rd[3:0], uartPkg::IirThre);
		apbRead(uartPkg::AddrIirFcr, rd);
		checkIir("IIR after THRE read", rd[3:0], uartPkg::IirNone);
		checkBit("INT after THRE read", INT, 1'b0);

		// Line status has the highest priority
		apbWrite(uartPkg::AddrIer, 8'h04);
		apbWrite(uartPkg::AddrLcr, 8'h1B);
		randomByte(b);
		sendFrame(8'h1B, b, ErrParity);
		waitInt();
		apbRead(uartPkg::AddrIirFcr, rd);
		checkIir("IIR line status", rd[3:0], uartPkg::IirRls);
		apbRead(uartPkg::AddrLsr, rd);
		checkBit("LSR PE with ELSI", rd[2], 1'b1);
		apbRead(uartPkg::AddrRbrThr, rd);
		checkByte("RBR with parity error", rd, b);
		apbRead(uartPkg::AddrIirFcr, rd);
		checkIir("IIR after LSR read", rd[3:0], uartPkg::IirNone);
		apbWrite(uartPkg::AddrIer, 8'h00);

		$display("Test passed");
		$finish;
	end

endmodule
